/* dsp_pkg.sv */
`default_nettype none

// sizes, host config and datapath word types for the drive slice
// lane 0 always sits in the low bits of every multi-lane word
package dsp_pkg;

	// lanes per adc and dac word
	localparam int lanes = 4;
	// bits per dac sample
	localparam int sample_w = 16;
	// raw adc word, all lanes together
	localparam int adc_w = 64;
	// dac word, all lanes together
	localparam int dac_w = 64;
	// acquisition buffer address, 16 entries
	localparam int acq_aw = 4;
	// envelope memory address, 16 entries
	localparam int env_aw = 4;
	// envelope word, one 32-bit i/q entry per lane
	localparam int env_w = 128;

	// dac source codes
	typedef enum logic [1:0] {
		sel_square = 2'd0,
		sel_ramp   = 2'd1,
		sel_env_i  = 2'd2,
		sel_env_q  = 2'd3
	} dac_sel_t;

	// host configuration
	// restart_stb is a one-cycle strobe, the rest are levels
	typedef struct packed {
		logic        restart_stb;
		dac_sel_t    dac_sel;
		logic [15:0] test_period;
	} dsp_cfg_t;

	// one write into the acquisition buffer
	typedef struct packed {
		logic              we;
		logic [acq_aw-1:0] addr;
		logic [adc_w-1:0]  data;
	} acq_wr_t;

	// i in the upper half, q in the lower half
	typedef struct packed {
		logic [sample_w-1:0] i;
		logic [sample_w-1:0] q;
	} env_iq_t;

	// envelope lane entry, stored raw by the host, played as i/q
	typedef union packed {
		logic [env_w/lanes-1:0] raw;
		env_iq_t                iq;
	} env_lane_t;

	// full envelope memory word
	typedef env_lane_t [lanes-1:0] env_word_t;

	// dac word, one sample per lane
	typedef logic [lanes-1:0][dac_w/lanes-1:0] dac_word_t;

endpackage

`default_nettype wire

/* dsp_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

// host config register, restart pulse and the two pattern timebases
module dsp_ctrl (
	input  wire                 dspif,
	input  wire                 rst_n,
	input  dsp_pkg::dsp_cfg_t   cfg,
	output logic                clear,
	output dsp_pkg::dac_sel_t   dac_sel,
	output logic [1:0]          square,
	output logic [11:0]         tick
);
	import dsp_pkg::*;

	// registered copy of the host fields
	dsp_cfg_t cfg_q;
	// previous strobe, for edge detection
	logic stb_q;
	// square wave down-counter
	logic [15:0] period_cnt;
	// counter expired, reload this cycle
	logic reload;

	// host side is asynchronous to the dsp clock domain logic,
	// so everything goes through one register first
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			cfg_q <= '0;
		end else begin
			cfg_q <= cfg;
		end
	end

	// source select straight from the config register
	assign dac_sel = cfg_q.dac_sel;

	// one pulse per strobe, even if the host holds it
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			stb_q <= 1'b0;
			clear <= 1'b0;
		end else begin
			stb_q <= cfg_q.restart_stb;
			clear <= cfg_q.restart_stb && !stb_q;
		end
	end

	assign reload = (period_cnt == 16'd0);

	// phase advances on every reload
	// each phase lasts test_period + 1 cycles
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			period_cnt <= '0;
			square     <= '0;
		end else if (reload) begin
			period_cnt <= cfg_q.test_period;
			square     <= square + 2'd1;
		end else begin
			period_cnt <= period_cnt - 16'd1;
		end
	end

	// free-running sample count for the ramp
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			tick <= '0;
		end else begin
			tick <= tick + 12'd1;
		end
	end

endmodule

`default_nettype wire

/* acq_writer.sv */
`timescale 1ns/1ns
`default_nettype none

// adc capture into the external acquisition buffer
// address restarts on clear and locks at the last entry
module acq_writer (
	input  wire                          dspif,
	input  wire                          rst_n,
	input  logic                         clear,
	input  logic [dsp_pkg::adc_w-1:0]    adc_in,
	output dsp_pkg::acq_wr_t             acq_wr
);
	import dsp_pkg::*;

	// adc input register
	logic [adc_w-1:0] adc_q;
	// write record, output register
	logic              we_q;
	logic [acq_aw-1:0] addr_q;
	logic [adc_w-1:0]  data_q;
	// last entry written, stop here
	logic last;

	assign last = we_q && (&addr_q);

	// payload path, two stages from the adc pins
	always_ff @(posedge dspif) begin
		adc_q  <= adc_in;
		data_q <= adc_q;
	end

	// write address
	// idle after reset until the host asks for a capture
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			we_q   <= 1'b0;
			addr_q <= '0;
		end else if (clear) begin
			we_q   <= 1'b1;
			addr_q <= '0;
		end else if (last) begin
			// buffer full, keep the first capture intact
			we_q <= 1'b0;
		end else if (we_q) begin
			addr_q <= addr_q + 1'b1;
		end
	end

	// pack the record for the buffer port
	always_comb begin
		acq_wr.we   = we_q;
		acq_wr.addr = addr_q;
		acq_wr.data = data_q;
	end

endmodule

`default_nettype wire

/* env_player.sv */
`timescale 1ns/1ns
`default_nettype none

// drive envelope playback from the external envelope memory
// memory answers one cycle after the address
module env_player (
	input  wire                          dspif,
	input  wire                          rst_n,
	input  logic                         clear,
	output logic [dsp_pkg::env_aw-1:0]   env_addr,
	input  dsp_pkg::env_word_t           env_data,
	output dsp_pkg::dac_word_t           env_i,
	output dsp_pkg::dac_word_t           env_q
);
	import dsp_pkg::*;

	// next read address
	logic [env_aw-1:0] addr_nxt;

	// free-running, wraps naturally at the top entry
	always_comb begin
		if (clear) begin
			addr_nxt = '0;
		end else begin
			addr_nxt = env_addr + 1'b1;
		end
	end

	// address register drives the memory directly
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			env_addr <= '0;
		end else begin
			env_addr <= addr_nxt;
		end
	end

	// split each returned word into i and q lanes
	// lane order is kept, lane 0 low
	always_ff @(posedge dspif) begin
		for (int j = 0; j < lanes; j++) begin
			env_i[j] <= env_data[j].iq.i;
			env_q[j] <= env_data[j].iq.q;
		end
	end

endmodule

`default_nettype wire

/* dac_mux.sv */
`timescale 1ns/1ns
`default_nettype none

// dac source select and output register
module dac_mux (
	input  wire                    dspif,
	input  wire                    rst_n,
	input  dsp_pkg::dac_sel_t      dac_sel,
	input  logic [1:0]             square,
	input  logic [11:0]            tick,
	input  dsp_pkg::dac_word_t     env_i,
	input  dsp_pkg::dac_word_t     env_q,
	output dsp_pkg::dac_word_t     dac
);
	import dsp_pkg::*;

	// square test word, same value on every lane
	dac_word_t square_word;
	// lane-tagged ramp
	dac_word_t ramp_word;
	// selected source before the output register
	dac_word_t dac_nxt;

	// phase 0..3 maps to 0000, 7fff, 8000, ffff
	always_comb begin
		for (int j = 0; j < lanes; j++) begin
			square_word[j] = {square[1], {(sample_w-1){square[0]}}};
		end
	end

	// upper 12 bits count, lower nibble names the lane
	always_comb begin
		for (int j = 0; j < lanes; j++) begin
			ramp_word[j] = {tick, 4'(j)};
		end
	end

	always_comb begin
		case (dac_sel)
			sel_square: begin
				dac_nxt = square_word;
			end
			sel_ramp: begin
				dac_nxt = ramp_word;
			end
			sel_env_i: begin
				dac_nxt = env_i;
			end
			sel_env_q: begin
				dac_nxt = env_q;
			end
			default: begin
				dac_nxt = square_word;
			end
		endcase
	end

	// registered output, zero after reset
	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			dac <= '0;
		end else begin
			dac <= dac_nxt;
		end
	end

endmodule

`default_nettype wire

/* dsp_top.sv */
`timescale 1ns/1ns
`default_nettype none

// qubit-drive dsp slice
// acquisition buffer and envelope memory live outside this level
module dsp_top (
	input  wire                          dspif,
	input  wire                          rst_n,
	input  dsp_pkg::dsp_cfg_t            cfg,
	input  logic [dsp_pkg::adc_w-1:0]    adc_in,
	input  dsp_pkg::env_word_t           env_data,
	output dsp_pkg::acq_wr_t             acq_wr,
	output logic [dsp_pkg::env_aw-1:0]   env_addr,
	output dsp_pkg::dac_word_t           dac
);
	import dsp_pkg::*;

	// restart pulse to both address counters
	logic clear;
	// registered source select
	dac_sel_t dac_sel;
	// square phase and ramp count
	logic [1:0]  square;
	logic [11:0] tick;
	// decoded envelope halves
	dac_word_t env_i;
	dac_word_t env_q;

	// config, restart and timebases
	dsp_ctrl u_ctrl (
		.dspif   (dspif),
		.rst_n   (rst_n),
		.cfg     (cfg),
		.clear   (clear),
		.dac_sel (dac_sel),
		.square  (square),
		.tick    (tick)
	);

	// adc capture
	acq_writer u_acq (
		.dspif  (dspif),
		.rst_n  (rst_n),
		.clear  (clear),
		.adc_in (adc_in),
		.acq_wr (acq_wr)
	);

	// envelope read side
	env_player u_env (
		.dspif    (dspif),
		.rst_n    (rst_n),
		.clear    (clear),
		.env_addr (env_addr),
		.env_data (env_data),
		.env_i    (env_i),
		.env_q    (env_q)
	);

	// dac output
	dac_mux u_dac (
		.dspif   (dspif),
		.rst_n   (rst_n),
		.dac_sel (dac_sel),
		.square  (square),
		.tick    (tick),
		.env_i   (env_i),
		.env_q   (env_q),
		.dac     (dac)
	);

endmodule

`default_nettype wire

/* dsp_properties.sv */
`timescale 1ns/1ns
`default_nettype none

// concurrent checks on the dsp_top ports
// failures are counted per behavior for the closing line
module dsp_properties (
	input wire                           dspif,
	input wire                           rst_n,
	input dsp_pkg::dsp_cfg_t             cfg,
	input logic [dsp_pkg::adc_w-1:0]     adc_in,
	input dsp_pkg::acq_wr_t              acq_wr,
	input logic [dsp_pkg::env_aw-1:0]    env_addr,
	input dsp_pkg::dac_word_t            dac
);
	import dsp_pkg::*;

	// history of the ports
	logic [adc_w-1:0] adc_d1;
	logic [adc_w-1:0] adc_d2;
	// strobe history, bit 0 is one cycle back
	logic [3:0] stb_d = '0;
	dac_sel_t sel_d1;
	dac_sel_t sel_d2;
	dac_sel_t sel_d3;
	logic [env_aw-1:0] addr_d1;
	logic [env_aw-1:0] addr_d2;
	logic [env_aw-1:0] addr_d3;
	acq_wr_t acq_d1;
	dac_word_t dac_d1;
	logic [15:0] tp_d1;
	logic rst_d1 = 1'b0;
	// cycles since reset release, saturating
	logic [3:0] warm;
	// cycles since test_period last changed
	logic [7:0] per_age;
	// square run tracking
	logic [15:0] run_len;
	logic [15:0] run_per;
	logic run_ok;
	logic settled;
	logic ok;
	logic sq_mode;
	logic sq_prev;
	logic ramp_mode;
	logic ramp_prev;
	dac_word_t env_i_exp;
	dac_word_t env_q_exp;
	dac_word_t ramp_exp;

	int err_capture = 0;
	int err_lock = 0;
	int err_square = 0;
	int err_ramp = 0;
	int err_env = 0;
	int err_reset = 0;

	// legal square words cycle 0000, 7fff, 8000, ffff
	function automatic logic [15:0] next_square(input logic [15:0] v);
		case (v)
			16'h0000: next_square = 16'h7fff;
			16'h7fff: next_square = 16'h8000;
			16'h8000: next_square = 16'hffff;
			default:  next_square = 16'h0000;
		endcase
	endfunction

	function automatic logic legal_square(input dac_word_t w);
		logic good;
		good = (w[0] == 16'h0000) || (w[0] == 16'h7fff) ||
			(w[0] == 16'h8000) || (w[0] == 16'hffff);
		for (int j = 1; j < lanes; j++) begin
			good = good && (w[j] == w[0]);
		end
		return good;
	endfunction

	always_comb begin
		for (int j = 0; j < lanes; j++) begin
			// memory lane holds addr*16+j in i, its inverse in q
			// address register, memory and split register, then dac register
			env_i_exp[j] = {8'h00, addr_d3, 4'(j)};
			env_q_exp[j] = ~{8'h00, addr_d3, 4'(j)};
			// count field up by one, lane tag fixed
			ramp_exp[j] = {dac_d1[j][15:4] + 12'd1, 4'(j)};
		end
	end

	assign ok = (warm >= 4'd5);
	assign sq_mode = (sel_d2 == sel_square);
	assign sq_prev = (sel_d3 == sel_square);
	assign ramp_mode = (sel_d2 == sel_ramp);
	assign ramp_prev = (sel_d3 == sel_ramp);
	assign settled = (per_age >= 8'd2) && (cfg.test_period == tp_d1) && sq_prev;

	always_ff @(posedge dspif) begin
		adc_d1  <= adc_in;
		adc_d2  <= adc_d1;
		stb_d   <= {stb_d[2:0], cfg.restart_stb};
		sel_d1  <= cfg.dac_sel;
		sel_d2  <= sel_d1;
		sel_d3  <= sel_d2;
		addr_d1 <= env_addr;
		addr_d2 <= addr_d1;
		addr_d3 <= addr_d2;
		acq_d1  <= acq_wr;
		dac_d1  <= dac;
		tp_d1   <= cfg.test_period;
		rst_d1  <= rst_n;
	end

	always_ff @(posedge dspif) begin
		if (!rst_n) begin
			warm <= '0;
		end else if (warm != 4'hf) begin
			warm <= warm + 4'd1;
		end
		if (cfg.test_period != tp_d1) begin
			per_age <= '0;
		end else if (per_age != 8'hff) begin
			per_age <= per_age + 8'd1;
		end
		// a run starts at each value change in square mode
		if (!rst_n || !sq_mode) begin
			run_len <= '0;
			run_per <= '0;
			run_ok  <= 1'b0;
		end else if (dac != dac_d1) begin
			run_len <= 16'd1;
			run_per <= cfg.test_period;
			run_ok  <= settled;
		end else begin
			run_len <= run_len + 16'd1;
		end
	end

	// capture payload, two registers deep
	a_cap_data: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		acq_wr.we |-> acq_wr.data == adc_d2)
		else begin
			err_capture++;
			$error("ERROR capture data: expected %h actual %h",
				$sampled(adc_d2), $sampled(acq_wr.data));
		end

	a_cap_restart: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(stb_d[2] && !stb_d[3]) |-> acq_wr.we && acq_wr.addr == '0)
		else begin
			err_capture++;
			$error("ERROR capture restart: expected we 1 addr 0 actual we %0d addr %h",
				$sampled(acq_wr.we), $sampled(acq_wr.addr));
		end

	a_cap_step: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(acq_wr.we && acq_d1.we && !stb_d[2]) |-> acq_wr.addr == acq_d1.addr + 4'd1)
		else begin
			err_capture++;
			$error("ERROR capture step: expected %h actual %h",
				$sampled(acq_d1.addr + 4'd1), $sampled(acq_wr.addr));
		end

	// full buffer drops we and holds the last address
	a_lock_enter: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(acq_wr.we && acq_wr.addr == '1 && !stb_d[1]) |=>
		!acq_wr.we && acq_wr.addr == '1)
		else begin
			err_lock++;
			$error("ERROR lock enter: expected we 0 addr f actual we %0d addr %h",
				$sampled(acq_wr.we), $sampled(acq_wr.addr));
		end

	a_lock_hold: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(!acq_wr.we && !stb_d[1]) |=> !acq_wr.we && acq_wr.addr == acq_d1.addr)
		else begin
			err_lock++;
			$error("ERROR lock hold: expected we 0 addr %h actual we %0d addr %h",
				$sampled(acq_d1.addr), $sampled(acq_wr.we), $sampled(acq_wr.addr));
		end

	a_sq_value: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		sq_mode |-> legal_square(dac))
		else begin
			err_square++;
			$error("ERROR square value: expected %h actual %h",
				{lanes{$sampled(dac[0])}}, $sampled(dac));
		end

	a_sq_order: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(sq_mode && sq_prev && dac != dac_d1) |-> dac[0] == next_square(dac_d1[0]))
		else begin
			err_square++;
			$error("ERROR square order: expected %h actual %h",
				next_square($sampled(dac_d1[0])), $sampled(dac[0]));
		end

	a_sq_len: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(sq_mode && sq_prev && dac != dac_d1 && run_ok) |-> run_len == run_per + 16'd1)
		else begin
			err_square++;
			$error("ERROR square length: expected %0d actual %0d",
				$sampled(run_per) + 1, $sampled(run_len));
		end

	a_ramp: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(ramp_mode && ramp_prev) |-> dac == ramp_exp)
		else begin
			err_ramp++;
			$error("ERROR ramp: expected %h actual %h", $sampled(ramp_exp), $sampled(dac));
		end

	a_env_i: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(sel_d2 == sel_env_i) |-> dac == env_i_exp)
		else begin
			err_env++;
			$error("ERROR env i: expected %h actual %h", $sampled(env_i_exp), $sampled(dac));
		end

	a_env_q: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		(sel_d2 == sel_env_q) |-> dac == env_q_exp)
		else begin
			err_env++;
			$error("ERROR env q: expected %h actual %h", $sampled(env_q_exp), $sampled(dac));
		end

	// read address wraps freely, back to 0 after a restart
	a_env_step: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		!stb_d[2] |-> env_addr == addr_d1 + 4'd1)
		else begin
			err_env++;
			$error("ERROR env addr: expected %h actual %h",
				$sampled(addr_d1 + 4'd1), $sampled(env_addr));
		end

	a_env_restart: assert property (@(posedge dspif) disable iff (!rst_n || !ok)
		stb_d[2] |-> env_addr == '0)
		else begin
			err_env++;
			$error("ERROR env restart: expected 0 actual %h", $sampled(env_addr));
		end

	// first cycle out of reset
	a_reset: assert property (@(posedge dspif)
		(rst_n && !rst_d1) |-> !acq_wr.we && dac == '0)
		else begin
			err_reset++;
			$error("ERROR reset: expected we 0 dac 0 actual we %0d dac %h",
				$sampled(acq_wr.we), $sampled(dac));
		end

endmodule

bind dsp_top dsp_properties u_props (.*);

`default_nettype wire

/* tb_dsp.sv */
`timescale 1ns/1ns
`default_nettype none

// testbench for the drive slice
// checking lives in the bound property module
module tb_dsp;
	import dsp_pkg::*;

	localparam logic [31:0] seed = 32'hd379660e;
	localparam int reset_len = 3;
	localparam int sq3_len = 40;
	localparam int sq5_len = 60;
	localparam int ramp_len = 30;
	localparam int env_len = 30;
	localparam int gap_len = 6;
	localparam int lock_len = 40;
	localparam int hold_len = 10;
	// all phases plus strobes and a margin
	localparam int timeout_limit = reset_len + 8 + sq3_len + sq5_len + ramp_len
		+ 2 * env_len + gap_len + lock_len + hold_len + 100;

	logic dspif;
	logic rst_n;
	dsp_cfg_t cfg;
	logic [adc_w-1:0] adc_in;
	env_word_t env_data;
	acq_wr_t acq_wr;
	logic [env_aw-1:0] env_addr;
	dac_word_t dac;

	// address seen by the memory model last cycle
	logic [env_aw-1:0] mem_addr_q;
	logic [31:0] lfsr;
	int cycles;
	int tb_errors;
	int total;
	logic locked;

	dsp_top DUT (
		.dspif    (dspif),
		.rst_n    (rst_n),
		.cfg      (cfg),
		.adc_in   (adc_in),
		.env_data (env_data),
		.acq_wr   (acq_wr),
		.env_addr (env_addr),
		.dac      (dac)
	);

	initial begin
		dspif = 1'b0;
	end

	always #5 dspif = ~dspif;

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per adc bit
	task automatic fill_adc();
		for (int b = 0; b < adc_w; b++) begin
			adc_in[b] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// i = addr*16 + lane, q = ~i
	function automatic env_word_t mem_word(input logic [env_aw-1:0] a);
		env_word_t w;
		for (int j = 0; j < lanes; j++) begin
			w[j].iq.i = {8'h00, a, 4'(j)};
			w[j].iq.q = ~{8'h00, a, 4'(j)};
		end
		return w;
	endfunction

	// envelope memory, one cycle of read latency
	always @(negedge dspif) begin
		env_data <= mem_word(mem_addr_q);
		mem_addr_q <= env_addr;
		fill_adc();
	end

	task automatic idle(input int n);
		repeat (n) @(negedge dspif);
	endtask

	task automatic set_mode(input dac_sel_t sel, input logic [15:0] per);
		@(negedge dspif);
		cfg.dac_sel = sel;
		cfg.test_period = per;
	endtask

	// single-cycle restart strobe
	task automatic restart();
		@(negedge dspif);
		cfg.restart_stb = 1'b1;
		@(negedge dspif);
		cfg.restart_stb = 1'b0;
	endtask

	always @(posedge dspif) begin
		cycles++;
		if (cycles >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		cfg = '0;
		rst_n = 1'b0;
		adc_in = '0;
		lfsr = seed;
		mem_addr_q = '0;
		env_data = mem_word('0);
		cycles = 0;
		tb_errors = 0;
		locked = 1'b0;
		idle(reset_len);
		rst_n = 1'b1;
		idle(5);
		// a capture in the background of the pattern phases
		restart();
		set_mode(sel_square, 16'd3);
		idle(sq3_len);
		set_mode(sel_square, 16'd5);
		idle(sq5_len);
		set_mode(sel_ramp, 16'd5);
		idle(ramp_len);
		set_mode(sel_env_i, 16'd5);
		idle(env_len);
		set_mode(sel_env_q, 16'd5);
		idle(env_len);
		// second strobe lands mid-capture
		restart();
		idle(gap_len);
		restart();
		for (int n = 0; n < lock_len && !locked; n++) begin
			@(negedge dspif);
			locked = !acq_wr.we && (acq_wr.addr == '1);
		end
		if (!locked) begin
			tb_errors++;
			$display("capture did not lock within %0d cycles of the restart", lock_len);
		end
		idle(hold_len);
		total = tb_errors + DUT.u_props.err_capture + DUT.u_props.err_lock
			+ DUT.u_props.err_square + DUT.u_props.err_ramp
			+ DUT.u_props.err_env + DUT.u_props.err_reset;
		$display("errors: capture %0d lock %0d square %0d ramp %0d env %0d reset %0d tb %0d",
			DUT.u_props.err_capture, DUT.u_props.err_lock, DUT.u_props.err_square,
			DUT.u_props.err_ramp, DUT.u_props.err_env, DUT.u_props.err_reset, tb_errors);
		if (total == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
dsp_pkg.sv
dsp_ctrl.sv
acq_writer.sv
env_player.sv
dac_mux.sv
dsp_top.sv
dsp_properties.sv
tb_dsp.sv

/* Bender.yml */
package:
  name: dsp_slice

sources:
  - dsp_pkg.sv
  - dsp_ctrl.sv
  - acq_writer.sv
  - env_player.sv
  - dac_mux.sv
  - dsp_top.sv
  - target: test
    files:
      - dsp_properties.sv
      - tb_dsp.sv
